// File: common/tagger_params.svh
`ifndef TAGGER_PARAMS_SVH
`define TAGGER_PARAMS_SVH

// Width of the free-running event timestamp
`define TS_W 39

// Full sample word as stored in the FIFO and sent to the host
// lost flag, strobe mask, delta and timestamp
`define SAMPLE_W 48

// Sample buffer entries, a power of two so the pointers wrap on their own
`define FIFO_DEPTH 8

// Upper nibble of a command byte that addresses the timer
`define CMD_GROUP 4'hA

`endif

// File: common/tag_types_pkg.sv
`include "tagger_params.svh"

package tag_types_pkg;

	// Free-running event time
	typedef logic [`TS_W-1:0] timestamp_t;

	// One bit per strobe channel
	typedef logic [3:0] strobe_t;

	// Delta input, carried into the sample as is
	typedef logic [3:0] delta_t;

	// Sample layout, MSB first
	// bit 47 lost, 46..43 strobe mask, 42..39 delta, 38..0 timestamp
	typedef logic [`SAMPLE_W-1:0] sample_t;

	// Accepted-sample counter, wraps
	typedef logic [15:0] count_t;

endpackage

// File: common/host_types_pkg.sv
package host_types_pkg;

	// Unit of transfer on both host ports
	typedef logic [7:0] byte_t;

	// Action bits in the low nibble of a command byte
	typedef enum logic [3:0]
	{
		ACT_START = 4'b0001,
		ACT_STOP  = 4'b0010,
		ACT_CLEAR = 4'b0100
	} cmd_action_t;

	// Serializer handshake states
	typedef enum logic [1:0]
	{
		IDLE,
		DRIVE,
		WAIT_ACK_HI,
		WAIT_ACK_LO
	} ser_state_t;

endpackage

// File: hdl/cmd_decoder.sv
`include "tagger_params.svh"

module cmd_decoder
	import host_types_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  cmd_wr,
	input  byte_t cmd_in,
	output logic  operate,
	output logic  ts_clear
);

	logic       group_hit;
	logic [3:0] action;
	logic       do_start;
	logic       do_stop;
	logic       do_clear;

	// Only bytes in the timer group are acted on
	assign group_hit = cmd_wr && (cmd_in[7:4] == `CMD_GROUP);
	assign action = cmd_in[3:0];

	assign do_start = group_hit && ((action & ACT_START) != 4'b0);
	assign do_stop  = group_hit && ((action & ACT_STOP) != 4'b0);
	assign do_clear = group_hit && ((action & ACT_CLEAR) != 4'b0);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			operate  <= 1'b0;
			ts_clear <= 1'b0;
		end
		else
		begin
			// Single-cycle pulse, low again unless another clear arrives
			ts_clear <= do_clear;

			// Stop has priority over start in the same byte
			if (do_stop)
				operate <= 1'b0;
			else if (do_start)
				operate <= 1'b1;
		end
	end

endmodule

// File: capture/strobe_capture.sv
`include "tagger_params.svh"

module strobe_capture
	import tag_types_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    operate,
	input  logic    ts_clear,
	input  strobe_t strobe_in,
	input  delta_t  delta_in,
	output logic    sample_valid,
	output sample_t sample_word
);

	timestamp_t ts_count;
	strobe_t    strobe_prev;
	strobe_t    rising;
	logic       event_hit;

	// Channel went high since the previous edge
	assign rising = strobe_in & ~strobe_prev;
	assign event_hit = operate && (rising != 4'b0);

	// Timestamp counter
	always_ff @(posedge clk)
	begin
		if (rst || ts_clear)
			ts_count <= '0;
		else if (operate)
			ts_count <= ts_count + 1'b1;
	end

	// Previous strobe input, tracked even while stopped so that
	// a level already high at start does not look like an edge
	always_ff @(posedge clk)
	begin
		if (rst)
			strobe_prev <= '0;
		else
			strobe_prev <= strobe_in;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			sample_valid <= 1'b0;
		else
			sample_valid <= event_hit;
	end

	// Sample payload
	// Lost flag is left clear, the FIFO fills it in
	always_ff @(posedge clk)
	begin
		if (event_hit)
			sample_word <= {1'b0, strobe_in, delta_in, ts_count};
	end

endmodule

// File: hdl/sample_fifo.sv
`include "tagger_params.svh"

module sample_fifo
	import tag_types_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    sample_valid,
	input  sample_t sample_word,
	input  logic    fifo_pop,
	output logic    fifo_empty,
	output sample_t head_word,
	output count_t  accepted_count
);

	localparam int AW = $clog2(`FIFO_DEPTH);
	localparam logic [AW:0] FULL_COUNT = (AW+1)'(`FIFO_DEPTH);

	sample_t     mem [`FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   fill;
	logic          full;
	logic          wr_en;
	logic          rd_en;
	logic          lost;

	assign full = (fill == FULL_COUNT);
	assign fifo_empty = (fill == '0);
	assign wr_en = sample_valid && !full;
	assign rd_en = fifo_pop && !fifo_empty;

	// Show-ahead output
	assign head_word = mem[rd_ptr];

	// Storage, with the pending lost flag folded into the top bit
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= {lost, sample_word[`SAMPLE_W-2:0]};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// Drop tracking and accepted count
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			lost <= 1'b0;
			accepted_count <= '0;
		end
		else if (sample_valid)
		begin
			if (full)
				lost <= 1'b1;
			else
			begin
				lost <= 1'b0;
				accepted_count <= accepted_count + 1'b1;
			end
		end
	end

endmodule

// File: hdl/byte_serializer.sv
`include "tagger_params.svh"

module byte_serializer
	import tag_types_pkg::*;
	import host_types_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    fifo_empty,
	input  sample_t head_word,
	output logic    fifo_pop,
	output logic    data_req,
	output byte_t   data,
	input  logic    data_ack
);

	localparam int BYTES = `SAMPLE_W / 8;

	ser_state_t state;
	logic [2:0] byte_idx;
	byte_t      cur_byte;
	logic       last_byte;

	// MSB first, byte 0 is bits 47..40
	assign cur_byte = head_word[(`SAMPLE_W - 8) - 8 * byte_idx +: 8];
	assign last_byte = (byte_idx == 3'(BYTES - 1));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= IDLE;
			byte_idx <= '0;
			fifo_pop <= 1'b0;
			data_req <= 1'b0;
		end
		else
		begin
			fifo_pop <= 1'b0;
			case (state)
				IDLE:
				begin
					byte_idx <= '0;
					// Wait out the pop cycle so fifo_empty is current
					if (!fifo_empty && !fifo_pop)
						state <= DRIVE;
				end
				DRIVE:
				begin
					data_req <= 1'b1;
					state <= WAIT_ACK_HI;
				end
				WAIT_ACK_HI:
				begin
					if (data_ack)
					begin
						data_req <= 1'b0;
						state <= WAIT_ACK_LO;
					end
				end
				WAIT_ACK_LO:
				begin
					// Byte done once the host releases ack
					if (!data_ack)
					begin
						if (last_byte)
						begin
							fifo_pop <= 1'b1;
							state <= IDLE;
						end
						else
						begin
							byte_idx <= byte_idx + 1'b1;
							state <= DRIVE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Byte register, loaded on the edge that raises data_req and held until the next byte
	always_ff @(posedge clk)
	begin
		if (state == DRIVE)
			data <= cur_byte;
	end

endmodule

// File: hdl/timetag_top.sv
module timetag_top
	import tag_types_pkg::*;
	import host_types_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    cmd_wr,
	input  byte_t   cmd_in,
	input  strobe_t strobe_in,
	input  delta_t  delta_in,
	output logic    data_req,
	output byte_t   data,
	input  logic    data_ack,
	output logic    capture_operate,
	output count_t  accepted_count
);

	logic    operate;
	logic    ts_clear;
	logic    sample_valid;
	sample_t sample_word;
	logic    fifo_empty;
	sample_t head_word;
	logic    fifo_pop;

	assign capture_operate = operate;

	cmd_decoder cmd_decoder_inst (
		.clk      (clk),
		.rst      (rst),
		.cmd_wr   (cmd_wr),
		.cmd_in   (cmd_in),
		.operate  (operate),
		.ts_clear (ts_clear)
	);

	strobe_capture strobe_capture_inst (
		.clk          (clk),
		.rst          (rst),
		.operate      (operate),
		.ts_clear     (ts_clear),
		.strobe_in    (strobe_in),
		.delta_in     (delta_in),
		.sample_valid (sample_valid),
		.sample_word  (sample_word)
	);

	sample_fifo sample_fifo_inst (
		.clk            (clk),
		.rst            (rst),
		.sample_valid   (sample_valid),
		.sample_word    (sample_word),
		.fifo_pop       (fifo_pop),
		.fifo_empty     (fifo_empty),
		.head_word      (head_word),
		.accepted_count (accepted_count)
	);

	// Host side of the data path
	byte_serializer byte_serializer_inst (
		.clk        (clk),
		.rst        (rst),
		.fifo_empty (fifo_empty),
		.head_word  (head_word),
		.fifo_pop   (fifo_pop),
		.data_req   (data_req),
		.data       (data),
		.data_ack   (data_ack)
	);

endmodule

// File: bench/timetag_sva.sv
`include "tagger_params.svh"

module timetag_sva
	import tag_types_pkg::*;
	import host_types_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input logic    cmd_wr,
	input byte_t   cmd_in,
	input strobe_t strobe_in,
	input logic    data_req,
	input byte_t   data,
	input logic    data_ack,
	input logic    capture_operate,
	input count_t  accepted_count
);

	logic        group_hit;
	strobe_t     strobe_prev;
	int unsigned event_total;
	int          failures = 0;

	assign group_hit = cmd_wr && (cmd_in[7:4] == `CMD_GROUP);

	// Strobe edges seen while operating, an upper bound for accepted samples
	always @(posedge clk)
	begin
		if (rst)
		begin
			strobe_prev <= '0;
			event_total <= 0;
		end
		else
		begin
			strobe_prev <= strobe_in;
			if (capture_operate && ((strobe_in & ~strobe_prev) != '0))
				event_total <= event_total + 1;
		end
	end

	reset_values: assert property (@(posedge clk)
		rst |=> !data_req && !capture_operate && (accepted_count == '0))
		else begin failures++; $error("Outputs not at reset values after reset"); end

	start_sets_operate: assert property (@(posedge clk) disable iff (rst)
		group_hit && (cmd_in[1:0] == 2'b01) |=> capture_operate)
		else begin failures++; $error("Start command did not set operate"); end

	stop_clears_operate: assert property (@(posedge clk) disable iff (rst)
		group_hit && cmd_in[1] |=> !capture_operate)
		else begin failures++; $error("Stop command did not clear operate"); end

	other_group_ignored: assert property (@(posedge clk) disable iff (rst)
		cmd_wr && (cmd_in[7:4] != `CMD_GROUP) |=> capture_operate == $past(capture_operate))
		else begin failures++; $error("Command outside the timer group changed operate"); end

	req_held_until_ack: assert property (@(posedge clk) disable iff (rst)
		data_req && !data_ack |=> data_req)
		else begin failures++; $error("data_req fell before data_ack was high"); end

	data_stable_during_req: assert property (@(posedge clk) disable iff (rst)
		data_req && $past(data_req) |-> data == $past(data))
		else begin failures++; $error("data changed while data_req was high"); end

	no_req_while_ack: assert property (@(posedge clk) disable iff (rst)
		!data_req && data_ack |=> !data_req)
		else begin failures++; $error("data_req rose while data_ack was still high"); end

	count_bounded: assert property (@(posedge clk) disable iff (rst)
		32'(accepted_count) <= event_total)
		else begin failures++; $error("accepted_count exceeds the number of events"); end

endmodule

bind timetag_top timetag_sva timetag_sva_inst (
	.clk             (clk),
	.rst             (rst),
	.cmd_wr          (cmd_wr),
	.cmd_in          (cmd_in),
	.strobe_in       (strobe_in),
	.data_req        (data_req),
	.data            (data),
	.data_ack        (data_ack),
	.capture_operate (capture_operate),
	.accepted_count  (accepted_count)
);

// File: bench/timetag_tb.sv
`include "tagger_params.svh"

module timetag_tb
	import tag_types_pkg::*;
	import host_types_pkg::*;
();

	localparam int TIMEOUT = 200;
	localparam int DEPTH = `FIFO_DEPTH;

	logic    clk;
	logic    rst;
	logic    cmd_wr;
	byte_t   cmd_in;
	strobe_t strobe_in;
	delta_t  delta_in;
	logic    data_req;
	byte_t   data;
	logic    data_ack;
	logic    capture_operate;
	count_t  accepted_count;

	integer seed;
	int     words_read;
	int     saw_lost;

	// Reference model state
	logic       m_op;
	logic       m_clr;
	logic       m_lost;
	timestamp_t m_ts;
	strobe_t    m_prev;
	int         m_accepted;
	sample_t    expected_q[$];

	timetag_top timetag_top_inst (
		.clk             (clk),
		.rst             (rst),
		.cmd_wr          (cmd_wr),
		.cmd_in          (cmd_in),
		.strobe_in       (strobe_in),
		.delta_in        (delta_in),
		.data_req        (data_req),
		.data            (data),
		.data_ack        (data_ack),
		.capture_operate (capture_operate),
		.accepted_count  (accepted_count)
	);

	always #2 clk = ~clk;

	// Model of commands, timestamp counter, edge detection and FIFO drops
	always @(posedge clk)
	begin
		if (rst)
		begin
			m_op = 1'b0;
			m_clr = 1'b0;
			m_lost = 1'b0;
			m_ts = '0;
			m_prev = '0;
			m_accepted = 0;
		end
		else
		begin
			if (m_op && ((strobe_in & ~m_prev) != '0))
			begin
				// Occupancy from accepted words minus words already read
				if (m_accepted - words_read < DEPTH)
				begin
					expected_q.push_back({m_lost, strobe_in, delta_in, m_ts});
					m_lost = 1'b0;
					m_accepted++;
				end
				else
					m_lost = 1'b1;
			end
			if (m_clr)
				m_ts = '0;
			else if (m_op)
				m_ts = m_ts + 1'b1;
			m_prev = strobe_in;
			m_clr = cmd_wr && (cmd_in[7:4] == `CMD_GROUP) && cmd_in[2];
			if (cmd_wr && (cmd_in[7:4] == `CMD_GROUP))
			begin
				if (cmd_in[1])
					m_op = 1'b0;
				else if (cmd_in[0])
					m_op = 1'b1;
			end
		end
	end

	// Assertion failures from the bound checker
	always @(negedge clk)
	begin
		if (timetag_top_inst.timetag_sva_inst.failures != 0)
			report_failure("A protocol or control assertion failed");
	end

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			report_failure($sformatf("ERR %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic send_cmd(input byte_t b);
		@(negedge clk);
		cmd_wr = 1'b1;
		cmd_in = b;
		@(negedge clk);
		cmd_wr = 1'b0;
		cmd_in = '0;
	endtask

	// One-cycle strobe pattern with a random delta
	task automatic pulse_strobe();
		strobe_t pattern;
		pattern = strobe_t'($random(seed));
		if (pattern == '0)
			pattern = 4'h1;
		@(negedge clk);
		strobe_in = pattern;
		delta_in = delta_t'($random(seed));
		@(negedge clk);
		strobe_in = '0;
		@(negedge clk);
	endtask

	task automatic wait_req(input logic level, input string what);
		int n;
		n = 0;
		while (data_req !== level)
		begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				report_failure($sformatf("Timed out waiting for data_req %0d while %s",
					level, what));
		end
	endtask

	// Host side of the four-phase handshake, six bytes MSB first
	task automatic read_word(output sample_t w);
		int d;
		w = '0;
		for (int i = 0; i < 6; i++)
		begin
			wait_req(1'b1, "waiting for a byte");
			w = {w[39:0], data};
			d = $random(seed) & 3;
			idle(d);
			data_ack = 1'b1;
			wait_req(1'b0, "waiting for data_req to fall");
			@(negedge clk);
			data_ack = 1'b0;
		end
	endtask

	task automatic check_next_word(input string name);
		sample_t w;
		sample_t exp;
		read_word(w);
		words_read++;
		if (w[`SAMPLE_W-1])
			saw_lost++;
		if (expected_q.size() == 0)
			report_failure("A word arrived that the model did not expect");
		exp = expected_q.pop_front();
		check_value(name, exp, w);
	endtask

	task automatic drain(input string name);
		while (expected_q.size() != 0)
			check_next_word(name);
	endtask

	// No host traffic and no newly accepted samples over a window
	task automatic expect_quiet(input int n);
		repeat (n)
		begin
			@(negedge clk);
			if (data_req)
				report_failure("data_req rose while capture was stopped");
		end
		check_value("stopped count", m_accepted, accepted_count);
	endtask

	initial
	begin
		seed = 32'hc567_66a1;
		words_read = 0;
		saw_lost = 0;
		clk = 1'b0;
		rst = 1'b1;
		cmd_wr = 1'b0;
		cmd_in = '0;
		strobe_in = '0;
		delta_in = '0;
		data_ack = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		idle(2);

		// Commands outside the group, then start and stop together
		send_cmd(8'h51);
		send_cmd(8'hA3);
		send_cmd(8'hA1);

		// Isolated events while operating
		for (int i = 0; i < 6; i++)
		begin
			idle($random(seed) & 7);
			pulse_strobe();
			check_next_word("sample content");
		end

		// Events while stopped
		send_cmd(8'hA2);
		repeat (3) pulse_strobe();
		expect_quiet(30);
		send_cmd(8'hA1);

		// Timestamp restart after clear
		send_cmd(8'hA4);
		idle(5 + ($random(seed) & 7));
		pulse_strobe();
		check_next_word("timestamp clear");
		idle(6);

		// Host holds off, so the FIFO fills and drops
		saw_lost = 0;
		repeat (DEPTH + 4) pulse_strobe();
		check_next_word("overflow");
		check_next_word("overflow");
		idle(6);
		pulse_strobe();
		pulse_strobe();
		drain("overflow");
		check_value("lost flag words", 1, saw_lost);

		idle(4);
		check_value("accepted count", m_accepted, accepted_count);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: all.f
+incdir+common
common/tag_types_pkg.sv
common/host_types_pkg.sv
hdl/cmd_decoder.sv
capture/strobe_capture.sv
hdl/sample_fifo.sv
hdl/byte_serializer.sv
hdl/timetag_top.sv
bench/timetag_sva.sv
bench/timetag_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the time tagger testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module timetag_tb -Mdir "$BUILD_DIR" -f all.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtimetag_tb" +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
